/* rtl/mem_pkg.sv */
package mem_pkg;

    // Store view of an instruction word
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Register-writing view, same bits
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        s_fmt_t s_fmt;
        i_fmt_t i_fmt;
    } inst_t;

    // Base opcodes
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // Store widths by funct3
    localparam logic [2:0] FNC_SB = 3'b000;
    localparam logic [2:0] FNC_SH = 3'b001;
    localparam logic [2:0] FNC_SW = 3'b010;

    // addi x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

    typedef enum logic [1:0] {
        SIZE_NONE = 2'd0,
        SIZE_B    = 2'd1,
        SIZE_H    = 2'd2,
        SIZE_W    = 2'd3
    } size_t;

    typedef struct packed {
        logic  dmem_en;
        logic  io_en;
        size_t size;
        logic  fwd_wdata;
        logic  is_branch;
        logic  bubble;
    } mem_ctrl_t;

    // Top address nibble
    localparam logic [3:0] REGION_DMEM = 4'h1;
    localparam logic [3:0] REGION_IO   = 4'h8;

    localparam int DMEM_ADDR_BITS = 14;

    // IO block offsets
    localparam logic [7:0] IO_UART_CTRL = 8'h00;
    localparam logic [7:0] IO_UART_TX   = 8'h08;
    localparam logic [7:0] IO_CYCLES    = 8'h10;
    localparam logic [7:0] IO_INSTS     = 8'h14;
    localparam logic [7:0] IO_COUNT_RST = 8'h18;
    localparam logic [7:0] IO_BRANCHES  = 8'h1C;
    localparam logic [7:0] IO_BR_GOOD   = 8'h20;

    // Short bit period keeps simulation fast
    localparam int CLOCKS_PER_BIT = 8;
    localparam int BAUD_CNT_W = $clog2(CLOCKS_PER_BIT);
    localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(CLOCKS_PER_BIT - 1);

endpackage

/* rtl/mem_decode.sv */
module mem_decode (
    input  mem_pkg::inst_t     inst,
    input  mem_pkg::inst_t     wb_inst,
    input  logic [31:0]        addr,
    output mem_pkg::mem_ctrl_t ctrl
);
    logic [6:0] opcode;
    logic [6:0] wb_opcode;
    logic       is_mem;
    logic       is_store;
    logic       wb_writes_rd;
    logic [3:0] region;

    // Opcode sits in the same bits for both views
    assign opcode    = inst.s_fmt.opcode;
    assign wb_opcode = wb_inst.i_fmt.opcode;
    assign region    = addr[31:28];
    assign is_store  = (opcode == mem_pkg::OPC_STORE);
    assign is_mem    = is_store || (opcode == mem_pkg::OPC_LOAD);

    // Formats that write rd in the write-back stage
    always_comb begin
        case (wb_opcode)
            mem_pkg::OPC_LOAD, mem_pkg::OPC_OP, mem_pkg::OPC_OP_IMM,
            mem_pkg::OPC_LUI, mem_pkg::OPC_AUIPC, mem_pkg::OPC_JAL,
            mem_pkg::OPC_JALR: wb_writes_rd = 1'b1;
            default:           wb_writes_rd = 1'b0;
        endcase
    end

    always_comb begin
        ctrl.dmem_en = is_mem && (region == mem_pkg::REGION_DMEM);
        ctrl.io_en   = is_mem && (region == mem_pkg::REGION_IO);
        // Non-stores never touch the write mask
        ctrl.size = mem_pkg::SIZE_NONE;
        if (is_store) begin
            case (inst.s_fmt.funct3)
                mem_pkg::FNC_SB: ctrl.size = mem_pkg::SIZE_B;
                mem_pkg::FNC_SH: ctrl.size = mem_pkg::SIZE_H;
                mem_pkg::FNC_SW: ctrl.size = mem_pkg::SIZE_W;
                default:         ctrl.size = mem_pkg::SIZE_NONE;
            endcase
        end
        // x0 is never a forwarding source
        ctrl.fwd_wdata = is_store && wb_writes_rd && (wb_inst.i_fmt.rd != 5'd0)
                         && (wb_inst.i_fmt.rd == inst.s_fmt.rs2);
        ctrl.is_branch = (opcode == mem_pkg::OPC_BRANCH);
        ctrl.bubble    = (inst == mem_pkg::NOP);
    end

endmodule

/* rtl/store_pack.sv */
module store_pack (
    input  logic [31:0]    data,
    input  logic [1:0]     offset,
    input  mem_pkg::size_t size,
    output logic [31:0]    din,
    output logic [3:0]     we
);

    always_comb begin
        din = data;
        we  = 4'b0000;
        case (size)
            mem_pkg::SIZE_B: begin
                // Byte copied to every lane, mask picks one
                din = {4{data[7:0]}};
                we  = 4'b0001 << offset;
            end
            mem_pkg::SIZE_H: begin
                din = {2{data[15:0]}};
                // Odd offset is misaligned, nothing written
                we  = offset[0] ? 4'b0000 : (4'b0011 << offset);
            end
            mem_pkg::SIZE_W: begin
                we = (offset == 2'b00) ? 4'b1111 : 4'b0000;
            end
            default: begin
                we = 4'b0000;
            end
        endcase
    end

    // Mask shape per store size
    always_comb begin
        if (size == mem_pkg::SIZE_B) begin
            assert final ($onehot(we) && we[offset]) else $error("byte mask not one lane");
        end
        if (size == mem_pkg::SIZE_H) begin
            assert final (offset[0] ? (we == 4'b0000) : (we == (offset[1] ? 4'b1100 : 4'b0011)))
                else $error("half-word mask not an aligned lane pair");
        end
        if (size == mem_pkg::SIZE_W && offset == 2'b00) begin
            assert final (we == 4'b1111) else $error("word mask not all lanes");
        end
        if (size == mem_pkg::SIZE_NONE) begin
            assert final (we == 4'b0000) else $error("mask set without a store");
        end
    end

endmodule

/* rtl/data_mem.sv */
module data_mem (
    input  logic                              clk,
    input  logic                              en,
    input  logic [3:0]                        we,
    input  logic [mem_pkg::DMEM_ADDR_BITS-1:0] addr,
    input  logic [31:0]                       din,
    output logic [31:0]                       dout
);
    // One word per address
    logic [31:0] mem [0:(2**mem_pkg::DMEM_ADDR_BITS)-1];

    // Lane writes, each byte gated by its mask bit
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= din[8*i +: 8];
                end
            end
        end
    end

    // Read sees the word before this edge's write
    always_ff @(posedge clk) begin
        if (en) begin
            dout <= mem[addr];
        end
    end

endmodule

/* rtl/baud_timer.sv */
module baud_timer (
    input  logic clk,
    input  logic reset,
    input  logic run,
    output logic tick
);
    logic [mem_pkg::BAUD_CNT_W-1:0] count;

    // Held at zero when idle so each frame starts a fresh period
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            count <= '0;
        end else if (count == mem_pkg::BAUD_LAST) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Last count of the bit period
    assign tick = run && (count == mem_pkg::BAUD_LAST);

endmodule

/* rtl/uart_tx_fsm.sv */
module uart_tx_fsm (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    input  logic       tick,
    output logic       tx_ready,
    output logic       run,
    output logic       serial_out
);
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t     state;
    logic [7:0] shift;
    logic [2:0] bit_idx;
    logic       accept;

    assign accept = tx_valid && tx_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            bit_idx <= 3'd0;
        end else begin
            case (state)
                IDLE: if (accept) state <= START;
                START: begin
                    if (tick) begin
                        state   <= DATA;
                        bit_idx <= 3'd0;
                    end
                end
                DATA: begin
                    if (tick) begin
                        // Eighth bit done
                        if (bit_idx == 3'd7) state <= STOP;
                        bit_idx <= bit_idx + 3'd1;
                    end
                end
                STOP: if (tick) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // LSB first, shifted out at the end of each data bit
    always_ff @(posedge clk) begin
        if (accept) begin
            shift <= tx_data;
        end else if (state == DATA && tick) begin
            shift <= shift >> 1;
        end
    end

    assign tx_ready = (state == IDLE);
    assign run      = (state != IDLE);

    // Line idles high
    always_comb begin
        case (state)
            START:   serial_out = 1'b0;
            DATA:    serial_out = shift[0];
            default: serial_out = 1'b1;
        endcase
    end

    // IO block must hold off while a frame is out
    valid_only_when_ready: assert property (@(posedge clk) disable iff (reset)
        !(tx_valid && !tx_ready)) else $error("tx_valid while transmitter busy");

    // Line moves only at a bit boundary or a new frame
    line_changes_on_tick: assert property (@(posedge clk) disable iff (reset)
        !tick && !accept |=> $stable(serial_out))
        else $error("serial line changed in the middle of a bit");

endmodule

/* rtl/mmio_regs.sv */
module mmio_regs (
    input  logic        clk,
    input  logic        reset,
    input  logic        en,
    input  logic [3:0]  we,
    input  logic [31:0] addr,
    input  logic [31:0] din,
    input  logic        bubble,
    input  logic        is_branch,
    input  logic        br_suc,
    input  logic        tx_ready,
    output logic [7:0]  tx_data,
    output logic        tx_valid,
    output logic [31:0] dout
);
    logic [31:0] cycles;
    logic [31:0] insts;
    logic [31:0] branches;
    logic [31:0] br_good;
    logic [31:0] rdata;
    logic [7:0]  offset;
    logic        sel;
    logic        wr;
    logic        count_rst;

    // Full decode, bits between the nibble and the offset must be zero
    assign sel    = en && (addr[31:28] == mem_pkg::REGION_IO) && (addr[27:8] == 20'd0);
    assign offset = addr[7:0];
    assign wr     = sel && (|we);

    // Dropped while a frame is still going out
    assign tx_valid  = wr && we[0] && (offset == mem_pkg::IO_UART_TX) && tx_ready;
    assign tx_data   = din[7:0];
    assign count_rst = wr && (offset == mem_pkg::IO_COUNT_RST);

    always_ff @(posedge clk) begin
        if (reset || count_rst) begin
            cycles   <= 32'd0;
            insts    <= 32'd0;
            branches <= 32'd0;
            br_good  <= 32'd0;
        end else begin
            cycles <= cycles + 32'd1;
            if (!bubble) insts <= insts + 32'd1;
            if (is_branch) branches <= branches + 32'd1;
            if (is_branch && br_suc) br_good <= br_good + 32'd1;
        end
    end

    // Unmapped and write-only offsets read zero
    always_comb begin
        case (offset)
            mem_pkg::IO_UART_CTRL: rdata = {31'd0, tx_ready};
            mem_pkg::IO_CYCLES:    rdata = cycles;
            mem_pkg::IO_INSTS:     rdata = insts;
            mem_pkg::IO_BRANCHES:  rdata = branches;
            mem_pkg::IO_BR_GOOD:   rdata = br_good;
            default:               rdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (sel) dout <= rdata;
    end

    // Good predictions are a subset of branches
    good_within_branches: assert property (@(posedge clk) disable iff (reset)
        br_good <= branches) else $error("prediction count exceeds branch count");

endmodule

/* rtl/mem_stage.sv */
module mem_stage (
    input  logic           clk,
    input  logic           reset,
    input  logic [31:0]    mem_pc,
    input  logic [31:0]    mem_alu,
    input  logic [31:0]    mem_rd2,
    input  mem_pkg::inst_t mem_inst,
    input  logic           mem_br_suc,
    input  logic [31:0]    wb_wdata,
    output logic           serial_out,
    output logic [31:0]    wb_alu,
    output logic [31:0]    wb_pc4,
    output mem_pkg::inst_t wb_inst,
    output logic [31:0]    wb_dmem_dout,
    output logic [31:0]    wb_io_dout
);
    mem_pkg::mem_ctrl_t ctrl;
    logic [31:0]        store_data;
    logic [31:0]        din;
    logic [3:0]         we;
    logic [7:0]         tx_data;
    logic               tx_valid;
    logic               tx_ready;
    logic               run;
    logic               tick;

    mem_decode u_decode (
        .inst    (mem_inst),
        .wb_inst (wb_inst),
        .addr    (mem_alu),
        .ctrl    (ctrl)
    );

    // Result still in write-back wins over the stale register read
    assign store_data = ctrl.fwd_wdata ? wb_wdata : mem_rd2;

    store_pack u_pack (
        .data   (store_data),
        .offset (mem_alu[1:0]),
        .size   (ctrl.size),
        .din    (din),
        .we     (we)
    );

    // Word address drops the byte offset
    data_mem u_dmem (
        .clk  (clk),
        .en   (ctrl.dmem_en),
        .we   (we),
        .addr (mem_alu[mem_pkg::DMEM_ADDR_BITS+1:2]),
        .din  (din),
        .dout (wb_dmem_dout)
    );

    mmio_regs u_io (
        .clk       (clk),
        .reset     (reset),
        .en        (ctrl.io_en),
        .we        (we),
        .addr      (mem_alu),
        .din       (din),
        .bubble    (ctrl.bubble),
        .is_branch (ctrl.is_branch),
        .br_suc    (mem_br_suc),
        .tx_ready  (tx_ready),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .dout      (wb_io_dout)
    );

    uart_tx_fsm u_tx (
        .clk        (clk),
        .reset      (reset),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tick       (tick),
        .tx_ready   (tx_ready),
        .run        (run),
        .serial_out (serial_out)
    );

    baud_timer u_baud (
        .clk   (clk),
        .reset (reset),
        .run   (run),
        .tick  (tick)
    );

    // Write-back pipeline registers, empty slot after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_pc4  <= 32'd0;
            wb_alu  <= 32'd0;
            wb_inst <= mem_pkg::NOP;
        end else begin
            wb_pc4  <= mem_pc + 32'd4;
            wb_alu  <= mem_alu;
            wb_inst <= mem_inst;
        end
    end

endmodule

/* sim/mem_stage_checks.sv */
module mem_stage_checks (
    input  logic           clk,
    input  logic           reset,
    input  logic [31:0]    mem_pc,
    input  logic [31:0]    mem_alu,
    input  mem_pkg::inst_t mem_inst,
    input  logic [31:0]    wb_pc4,
    input  logic [31:0]    wb_alu,
    input  mem_pkg::inst_t wb_inst,
    input  logic           dmem_chk,
    input  logic [31:0]    exp_dmem,
    input  logic [31:0]    wb_dmem_dout,
    input  logic           io_chk,
    input  logic [31:0]    exp_io,
    input  logic [31:0]    wb_io_dout,
    input  logic           exp_serial,
    input  logic           serial_out,
    output int             wb_errors,
    output int             dmem_errors,
    output int             io_errors,
    output int             uart_errors
);
    timeunit 1ns;
    timeprecision 100ps;

    // Inputs as they stood at the previous edge
    logic           last_reset;
    logic [31:0]    last_pc4;
    logic [31:0]    last_alu;
    mem_pkg::inst_t last_inst;
    logic           last_dmem_chk;
    logic [31:0]    last_exp_dmem;
    logic           last_io_chk;
    logic [31:0]    last_exp_io;

    initial begin
        wb_errors   = 0;
        dmem_errors = 0;
        io_errors   = 0;
        uart_errors = 0;
    end

    always @(posedge clk) begin
        last_reset    <= reset;
        // Write-back pc is the next sequential pc
        last_pc4      <= mem_pc + 32'd4;
        last_alu      <= mem_alu;
        last_inst     <= mem_inst;
        last_dmem_chk <= dmem_chk;
        last_exp_dmem <= exp_dmem;
        last_io_chk   <= io_chk;
        last_exp_io   <= exp_io;
    end

    // Empty slot right after reset
    wb_after_reset: assert property (@(posedge clk)
        (last_reset && !reset) |-> (wb_inst == mem_pkg::NOP && wb_pc4 == 32'd0
                                    && wb_alu == 32'd0))
        else begin
            wb_errors++;
            $display("Error wb_after_reset: expected inst %h pc4 0 alu 0, actual inst %h pc4 %h alu %h",
                     mem_pkg::NOP, $sampled(wb_inst), $sampled(wb_pc4), $sampled(wb_alu));
        end

    // One-cycle copy of the execute-stage values
    wb_pipeline: assert property (@(posedge clk) disable iff (reset)
        !last_reset |-> (wb_pc4 == last_pc4 && wb_alu == last_alu && wb_inst == last_inst))
        else begin
            wb_errors++;
            $display("Error wb_pipeline: expected pc4 %h alu %h inst %h, actual pc4 %h alu %h inst %h",
                     $sampled(last_pc4), $sampled(last_alu), $sampled(last_inst),
                     $sampled(wb_pc4), $sampled(wb_alu), $sampled(wb_inst));
        end

    // Load data one cycle after the address
    dmem_load: assert property (@(posedge clk) disable iff (reset)
        last_dmem_chk |-> (wb_dmem_dout == last_exp_dmem))
        else begin
            dmem_errors++;
            $display("Error dmem_load: expected %h, actual %h",
                     $sampled(last_exp_dmem), $sampled(wb_dmem_dout));
        end

    io_read: assert property (@(posedge clk) disable iff (reset)
        last_io_chk |-> (wb_io_dout == last_exp_io))
        else begin
            io_errors++;
            $display("Error io_read: expected %h, actual %h",
                     $sampled(last_exp_io), $sampled(wb_io_dout));
        end

    // Line level every cycle, idle included
    uart_line: assert property (@(posedge clk) disable iff (reset)
        serial_out == exp_serial)
        else begin
            uart_errors++;
            $display("Error uart_line: expected %b, actual %b",
                     $sampled(exp_serial), $sampled(serial_out));
        end

endmodule

/* sim/mem_stage_tb.sv */
module mem_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CPB          = mem_pkg::CLOCKS_PER_BIT;
    localparam int          N_WORDS      = 16;
    localparam int          N_RANDOM     = 400;
    localparam int          N_FRAMES     = 2;
    localparam int          FRAME_CYCLES = 10 * CPB;
    localparam int          N_INSTS      = 10 + N_WORDS + N_RANDOM + 4 * N_FRAMES + 20;
    // Each byte may hold the pipe for up to 12 bit periods of polling
    localparam int          MAX_CYCLES   = N_INSTS + N_FRAMES * 12 * CPB + 200;
    localparam logic [31:0] DMEM_BASE    = {mem_pkg::REGION_DMEM, 28'd0};

    logic           clk;
    logic           reset;
    logic [31:0]    mem_pc;
    logic [31:0]    mem_alu;
    logic [31:0]    mem_rd2;
    mem_pkg::inst_t mem_inst;
    logic           mem_br_suc;
    logic [31:0]    wb_wdata;
    logic           serial_out;
    logic [31:0]    wb_alu;
    logic [31:0]    wb_pc4;
    mem_pkg::inst_t wb_inst;
    logic [31:0]    wb_dmem_dout;
    logic [31:0]    wb_io_dout;

    // Expected values for the checker
    logic           dmem_chk;
    logic [31:0]    exp_dmem;
    logic           io_chk;
    logic [31:0]    exp_io;
    logic           exp_serial;
    int             wb_errors;
    int             dmem_errors;
    int             io_errors;
    int             uart_errors;

    // Reference model state
    logic [31:0]    ref_mem [N_WORDS];
    logic [31:0]    cnt_cycles;
    logic [31:0]    cnt_insts;
    logic [31:0]    cnt_branches;
    logic [31:0]    cnt_good;
    logic [7:0]     frame_byte;
    int             frame_pos;
    logic           frame_pending;
    logic           prev_count_rst;
    mem_pkg::inst_t prev_inst;
    logic           prev_br_suc;

    mem_stage u_dut (
        .clk          (clk),
        .reset        (reset),
        .mem_pc       (mem_pc),
        .mem_alu      (mem_alu),
        .mem_rd2      (mem_rd2),
        .mem_inst     (mem_inst),
        .mem_br_suc   (mem_br_suc),
        .wb_wdata     (wb_wdata),
        .serial_out   (serial_out),
        .wb_alu       (wb_alu),
        .wb_pc4       (wb_pc4),
        .wb_inst      (wb_inst),
        .wb_dmem_dout (wb_dmem_dout),
        .wb_io_dout   (wb_io_dout)
    );

    mem_stage_checks u_checks (
        .clk          (clk),
        .reset        (reset),
        .mem_pc       (mem_pc),
        .mem_alu      (mem_alu),
        .mem_inst     (mem_inst),
        .wb_pc4       (wb_pc4),
        .wb_alu       (wb_alu),
        .wb_inst      (wb_inst),
        .dmem_chk     (dmem_chk),
        .exp_dmem     (exp_dmem),
        .wb_dmem_dout (wb_dmem_dout),
        .io_chk       (io_chk),
        .exp_io       (exp_io),
        .wb_io_dout   (wb_io_dout),
        .exp_serial   (exp_serial),
        .serial_out   (serial_out),
        .wb_errors    (wb_errors),
        .dmem_errors  (dmem_errors),
        .io_errors    (io_errors),
        .uart_errors  (uart_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic mem_pkg::inst_t store_inst(logic [2:0] funct3, logic [4:0] rs2);
        mem_pkg::inst_t inst;
        inst              = '0;
        inst.s_fmt.opcode = mem_pkg::OPC_STORE;
        inst.s_fmt.funct3 = funct3;
        inst.s_fmt.rs1    = 5'd2;
        inst.s_fmt.rs2    = rs2;
        return inst;
    endfunction

    // Load (lw) or addi, imm of one so addi x0 is not a NOP
    function automatic mem_pkg::inst_t reg_inst(logic [6:0] opcode, logic [4:0] rd);
        mem_pkg::inst_t inst;
        inst              = '0;
        inst.i_fmt.opcode = opcode;
        inst.i_fmt.funct3 = (opcode == mem_pkg::OPC_LOAD) ? 3'b010 : 3'b000;
        inst.i_fmt.rd     = rd;
        inst.i_fmt.imm    = 12'd1;
        return inst;
    endfunction

    function automatic mem_pkg::inst_t branch_inst(logic [4:0] rs2);
        mem_pkg::inst_t inst;
        inst              = '0;
        inst.s_fmt.opcode = mem_pkg::OPC_BRANCH;
        inst.s_fmt.rs2    = rs2;
        return inst;
    endfunction

    function automatic logic [31:0] io_addr(logic [7:0] offset);
        return {mem_pkg::REGION_IO, 20'd0, offset};
    endfunction

    // Instruction in write-back overrides the register value
    function automatic logic forwards(mem_pkg::inst_t inst);
        logic writes;
        case (prev_inst.i_fmt.opcode)
            mem_pkg::OPC_LOAD, mem_pkg::OPC_OP, mem_pkg::OPC_OP_IMM, mem_pkg::OPC_LUI,
            mem_pkg::OPC_AUIPC, mem_pkg::OPC_JAL, mem_pkg::OPC_JALR: writes = 1'b1;
            default: writes = 1'b0;
        endcase
        return writes && prev_inst.i_fmt.rd != 5'd0 && prev_inst.i_fmt.rd == inst.s_fmt.rs2;
    endfunction

    // Misaligned half-words and words write nothing
    function automatic logic [3:0] lane_mask(logic [2:0] funct3, logic [1:0] offset);
        case (funct3)
            mem_pkg::FNC_SB: return 4'b0001 << offset;
            mem_pkg::FNC_SH: return (offset == 2'd0) ? 4'b0011 :
                                    (offset == 2'd2) ? 4'b1100 : 4'b0000;
            mem_pkg::FNC_SW: return (offset == 2'd0) ? 4'b1111 : 4'b0000;
            default:         return 4'b0000;
        endcase
    endfunction

    function automatic logic [7:0] lane_byte(logic [2:0] funct3, logic [31:0] data, int lane);
        case (funct3)
            mem_pkg::FNC_SB: return data[7:0];
            mem_pkg::FNC_SH: return 8'(data >> (8 * (lane % 2)));
            default:         return 8'(data >> (8 * lane));
        endcase
    endfunction

    function automatic logic [31:0] io_value(logic [7:0] offset);
        case (offset)
            mem_pkg::IO_UART_CTRL: return {31'd0, frame_pos < 0};
            mem_pkg::IO_CYCLES:    return cnt_cycles;
            mem_pkg::IO_INSTS:     return cnt_insts;
            mem_pkg::IO_BRANCHES:  return cnt_branches;
            mem_pkg::IO_BR_GOOD:   return cnt_good;
            default:               return 32'd0;
        endcase
    endfunction

    // Start bit, data LSB first, stop bit
    function automatic logic line_level();
        if (frame_pos < 0) return 1'b1;
        if (frame_pos < CPB) return 1'b0;
        if (frame_pos < 9 * CPB) return frame_byte[3'(frame_pos / CPB - 1)];
        return 1'b1;
    endfunction

    // Effects of the edge that just passed
    task automatic step_reference();
        if (reset || prev_count_rst) begin
            cnt_cycles   = 32'd0;
            cnt_insts    = 32'd0;
            cnt_branches = 32'd0;
            cnt_good     = 32'd0;
        end else begin
            cnt_cycles = cnt_cycles + 32'd1;
            if (prev_inst != mem_pkg::NOP) cnt_insts = cnt_insts + 32'd1;
            if (prev_inst.s_fmt.opcode == mem_pkg::OPC_BRANCH) begin
                cnt_branches = cnt_branches + 32'd1;
                if (prev_br_suc) cnt_good = cnt_good + 32'd1;
            end
        end
        if (frame_pending) begin
            frame_pos     = 0;
            frame_pending = 1'b0;
        end else if (frame_pos >= 0) begin
            frame_pos = frame_pos + 1;
            if (frame_pos == FRAME_CYCLES) frame_pos = -1;
        end
        exp_serial = line_level();
    endtask

    // One instruction per cycle, driven on the falling edge
    task automatic issue(input mem_pkg::inst_t inst, input logic [31:0] addr);
        logic [31:0] data;
        logic [3:0]  mask;
        logic        is_dmem;
        logic        is_io;
        @(negedge clk);
        step_reference();
        mem_inst       = inst;
        mem_alu        = addr;
        mem_pc         = $urandom;
        mem_rd2        = $urandom;
        wb_wdata       = $urandom;
        mem_br_suc     = 1'($urandom);
        prev_count_rst = 1'b0;
        is_dmem  = addr[31:28] == mem_pkg::REGION_DMEM;
        is_io    = addr[31:28] == mem_pkg::REGION_IO;
        dmem_chk = is_dmem && inst.i_fmt.opcode == mem_pkg::OPC_LOAD;
        io_chk   = is_io && inst.i_fmt.opcode == mem_pkg::OPC_LOAD;
        exp_dmem = ref_mem[addr[5:2]];
        exp_io   = io_value(addr[7:0]);
        if (inst.s_fmt.opcode == mem_pkg::OPC_STORE) begin
            data = forwards(inst) ? wb_wdata : mem_rd2;
            mask = lane_mask(inst.s_fmt.funct3, addr[1:0]);
            for (int i = 0; i < 4; i++) begin
                if (is_dmem && mask[i]) begin
                    ref_mem[addr[5:2]] = (ref_mem[addr[5:2]] & ~(32'hFF << (8 * i)))
                        | (32'(lane_byte(inst.s_fmt.funct3, data, i)) << (8 * i));
                end
            end
            // Dropped while a frame is on the line
            if (is_io && mask[0] && addr[7:0] == mem_pkg::IO_UART_TX && frame_pos < 0) begin
                frame_pending = 1'b1;
                frame_byte    = data[7:0];
            end
            prev_count_rst = is_io && (|mask) && addr[7:0] == mem_pkg::IO_COUNT_RST;
        end
        prev_inst   = inst;
        prev_br_suc = mem_br_suc;
    endtask

    function automatic logic [7:0] io_offset(int pick);
        case (pick)
            0:       return mem_pkg::IO_UART_CTRL;
            1:       return mem_pkg::IO_CYCLES;
            2:       return mem_pkg::IO_INSTS;
            3:       return mem_pkg::IO_BRANCHES;
            4:       return mem_pkg::IO_BR_GOOD;
            default: return 8'h04;
        endcase
    endfunction

    // Small rd/rs2 range so forwarding hits often, x0 included
    task automatic random_op();
        int          kind;
        logic [31:0] addr;
        kind = $urandom_range(0, 5);
        addr = DMEM_BASE | {26'd0, 4'($urandom_range(0, N_WORDS - 1)), 2'($urandom)};
        case (kind)
            0: issue(store_inst(3'($urandom_range(0, 2)), 5'($urandom_range(0, 3))), addr);
            1: issue(reg_inst(mem_pkg::OPC_LOAD, 5'($urandom_range(0, 3))), addr & ~32'd3);
            2: issue(reg_inst(mem_pkg::OPC_OP_IMM, 5'($urandom_range(0, 3))), $urandom);
            3: issue(branch_inst(5'($urandom_range(0, 3))), $urandom);
            4: issue(mem_pkg::NOP, $urandom);
            default: issue(reg_inst(mem_pkg::OPC_LOAD, 5'd0),
                           io_addr(io_offset($urandom_range(0, 5))));
        endcase
    endtask

    // Byte out, a second store while busy, then poll until ready
    task automatic send_frame();
        issue(store_inst(mem_pkg::FNC_SW, 5'd6), io_addr(mem_pkg::IO_UART_TX));
        issue(store_inst(mem_pkg::FNC_SW, 5'd7), io_addr(mem_pkg::IO_UART_TX));
        do begin
            issue(reg_inst(mem_pkg::OPC_LOAD, 5'd0), io_addr(mem_pkg::IO_UART_CTRL));
        end while (wb_io_dout[0] !== 1'b1);
    endtask

    initial begin
        int total;
        void'($urandom(32'ha0d1a504));
        reset          = 1'b1;
        mem_pc         = 32'd0;
        mem_alu        = 32'd0;
        mem_rd2        = 32'd0;
        mem_inst       = mem_pkg::NOP;
        mem_br_suc     = 1'b0;
        wb_wdata       = 32'd0;
        dmem_chk       = 1'b0;
        io_chk         = 1'b0;
        exp_dmem       = 32'd0;
        exp_io         = 32'd0;
        exp_serial     = 1'b1;
        frame_pos      = -1;
        frame_pending  = 1'b0;
        prev_count_rst = 1'b0;
        prev_inst      = mem_pkg::NOP;
        prev_br_suc    = 1'b0;
        repeat (10) issue(mem_pkg::NOP, 32'd0);
        reset = 1'b0;
        // Every word of the window gets a known value first
        for (int w = 0; w < N_WORDS; w++) begin
            issue(store_inst(mem_pkg::FNC_SW, 5'd5), DMEM_BASE + 32'(w * 4));
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            random_op();
        end
        repeat (N_FRAMES) send_frame();
        // Counters from zero after a clear
        issue(store_inst(mem_pkg::FNC_SW, 5'd0), io_addr(mem_pkg::IO_COUNT_RST));
        repeat (3) issue(branch_inst(5'd1), 32'd0);
        repeat (2) issue(mem_pkg::NOP, 32'd0);
        for (int k = 0; k < 5; k++) begin
            issue(reg_inst(mem_pkg::OPC_LOAD, 5'd0), io_addr(io_offset(k)));
        end
        issue(reg_inst(mem_pkg::OPC_LOAD, 5'd0), io_addr(mem_pkg::IO_CYCLES));
        repeat (3) issue(mem_pkg::NOP, 32'd0);
        total = wb_errors + dmem_errors + io_errors + uart_errors;
        $display("errors: wb %0d, dmem %0d, io %0d, uart %0d",
                 wb_errors, dmem_errors, io_errors, uart_errors);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(MAX_CYCLES * 4);
        $display("watchdog expired after %0d cycles, the run did not finish", MAX_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

/* build.f */
rtl/mem_pkg.sv
rtl/mem_decode.sv
rtl/store_pack.sv
rtl/data_mem.sv
rtl/baud_timer.sv
rtl/uart_tx_fsm.sv
rtl/mmio_regs.sv
rtl/mem_stage.sv
sim/mem_stage_checks.sv
sim/mem_stage_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = mem_stage_tb
FILELIST  = build.f
BUILD_DIR = obj_dir
PASS_MSG  = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
